// ==== hw/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // Command kinds produced by the decoder
    typedef enum logic [2:0] {
        OP_WRITE   = 3'd0,
        OP_SET     = 3'd1,
        OP_CLEAR   = 3'd2,
        OP_ECALL   = 3'd3,
        OP_MRET    = 3'd4,
        OP_ILLEGAL = 3'd5
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    // SYSTEM instruction layout; rs1 doubles as the 5-bit immediate
    typedef struct packed {
        logic [11:0] funct12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } sys_instr_t;

    typedef struct packed {
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] wdata;
        logic        wr_en;
        logic [31:0] pc;
        logic [31:0] instr;
    } csr_cmd_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        redirect;
        logic [31:0] target;
    } csr_rsp_t;

    typedef struct packed {
        logic [18:0] rsv_31_13;
        logic [1:0]  mpp;
        logic [2:0]  rsv_10_8;
        logic        mpie;
        logic [2:0]  rsv_6_4;
        logic        mie;
        logic [2:0]  rsv_2_0;
    } mstatus_t;

    localparam logic [6:0]  OPCODE_SYSTEM = 7'b1110011;
    localparam logic [11:0] FUNCT12_ECALL = 12'h000;
    localparam logic [11:0] FUNCT12_MRET  = 12'h302;

    // Machine-level CSR addresses
    localparam logic [11:0] CSR_MVENDORID = 12'hf11;
    localparam logic [11:0] CSR_MARCHID   = 12'hf12;
    localparam logic [11:0] CSR_MIMPID    = 12'hf13;
    localparam logic [11:0] CSR_MHARTID   = 12'hf14;
    localparam logic [11:0] CSR_MSTATUS   = 12'h300;
    localparam logic [11:0] CSR_MISA      = 12'h301;
    localparam logic [11:0] CSR_MIE       = 12'h304;
    localparam logic [11:0] CSR_MTVEC     = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_MEPC      = 12'h341;
    localparam logic [11:0] CSR_MCAUSE    = 12'h342;
    localparam logic [11:0] CSR_MTVAL     = 12'h343;

    localparam logic [31:0] CAUSE_ILLEGAL = 32'd2;
    localparam logic [31:0] CAUSE_ECALL_U = 32'd8;
    localparam logic [31:0] CAUSE_ECALL_M = 32'd11;

    localparam logic [31:0] MVENDORID_VAL = 32'd0;
    localparam logic [31:0] MARCHID_VAL   = 32'd0;
    localparam logic [31:0] MIMPID_VAL    = 32'd1;
    // RV32I
    localparam logic [31:0] MISA_VAL      = 32'h4000_0100;

    localparam logic [31:0] MIE_MASK      = 32'h0000_0888;
    localparam logic [31:0] MSTATUS_MASK  = 32'h0000_1888;
    localparam logic [31:0] MTVEC_MASK    = 32'hffff_fffc;

endpackage

`default_nettype wire

// ==== hw/csr_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_cmd_decoder import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] pc,
    output logic        cmd_valid,
    output csr_cmd_t    cmd
);

    sys_instr_t fields;
    csr_op_e    op;
    logic       is_imm;
    logic       wr_en;
    csr_cmd_t   cmd_next;

    assign fields = sys_instr_t'(instr);
    assign is_imm = fields.funct3[2];

    always_comb begin
        op = OP_ILLEGAL;
        if (fields.opcode == OPCODE_SYSTEM) begin
            case (fields.funct3)
                3'b000: begin
                    if (fields.funct12 == FUNCT12_ECALL) begin
                        op = OP_ECALL;
                    end else if (fields.funct12 == FUNCT12_MRET) begin
                        op = OP_MRET;
                    end
                end
                3'b001, 3'b101: op = OP_WRITE;
                3'b010, 3'b110: op = OP_SET;
                3'b011, 3'b111: op = OP_CLEAR;
                default:        op = OP_ILLEGAL;
            endcase
        end
    end

    // Set and clear with x0 or a zero immediate are pure reads
    always_comb begin
        wr_en = 1'b0;
        if (op == OP_WRITE) begin
            wr_en = 1'b1;
        end else if (op == OP_SET || op == OP_CLEAR) begin
            wr_en = (fields.rs1 != 5'd0);
        end
    end

    always_comb begin
        cmd_next.op    = op;
        cmd_next.addr  = fields.funct12;
        cmd_next.wdata = is_imm ? {27'd0, fields.rs1} : rs1_data;
        cmd_next.wr_en = wr_en;
        cmd_next.pc    = pc;
        cmd_next.instr = instr;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            cmd <= cmd_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/csr_cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_cmd_fifo import csr_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  csr_cmd_t push_cmd,
    input  logic     pop,
    output csr_cmd_t head,
    output logic     not_empty,
    output logic     overflow
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

    csr_cmd_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    // A pop in the same cycle frees the slot for a push into a full buffer
    assign do_pop  = pop && not_empty;
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
            if (push && !do_push) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

endmodule

`default_nettype wire

// ==== hw/csr_mstatus_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_mstatus_reg import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        trap_take,
    input  logic        mret_take,
    input  logic        wr_en,
    input  logic [31:0] wdata,
    output mstatus_t    mstatus,
    output priv_e       priv
);

    mstatus_t wr_val;
    logic     mpp_legal;

    assign wr_val = mstatus_t'(wdata & MSTATUS_MASK);

    // MPP is WARL and keeps only U and M
    assign mpp_legal = (wr_val.mpp == PRIV_U) || (wr_val.mpp == PRIV_M);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus <= '0;
            priv    <= PRIV_M;
        end else if (trap_take) begin
            mstatus.mpie <= mstatus.mie;
            mstatus.mie  <= 1'b0;
            mstatus.mpp  <= priv;
            priv         <= PRIV_M;
        end else if (mret_take) begin
            mstatus.mie  <= mstatus.mpie;
            mstatus.mpie <= 1'b1;
            mstatus.mpp  <= PRIV_U;
            priv         <= priv_e'(mstatus.mpp);
        end else if (wr_en) begin
            mstatus.mie  <= wr_val.mie;
            mstatus.mpie <= wr_val.mpie;
            if (mpp_legal) begin
                mstatus.mpp <= wr_val.mpp;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file import csr_pkg::*; #(
    parameter logic [31:0] HART_ID    = 32'd0,
    parameter logic [31:0] MEPC_RESET = 32'h0001_0000
) (
    input  logic     clk,
    input  logic     rst_n,
    input  csr_cmd_t head,
    input  logic     not_empty,
    output logic     pop,
    output logic     rsp_valid,
    output csr_rsp_t rsp,
    output priv_e    priv
);

    csr_cmd_t    cmd_q;
    logic        busy;
    mstatus_t    mstatus;
    logic [31:0] mie_q;
    logic [31:0] mtvec_q;
    logic [31:0] mscratch_q;
    logic [31:0] mepc_q;
    logic [31:0] mcause_q;
    logic [31:0] mtval_q;

    logic [31:0] old_val;
    logic        addr_ok;
    logic [31:0] new_val;
    logic        is_csr;
    logic        csr_illegal;
    logic        illegal;
    logic        trap;
    logic        mret;
    logic        csr_write;
    logic [31:0] cause;

    // Read cycle when idle and write-back cycle while busy
    assign pop = !busy && not_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            busy      <= pop;
            rsp_valid <= busy;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cmd_q <= head;
        end
    end

    always_comb begin
        addr_ok = 1'b1;
        case (cmd_q.addr)
            CSR_MVENDORID: old_val = MVENDORID_VAL;
            CSR_MARCHID:   old_val = MARCHID_VAL;
            CSR_MIMPID:    old_val = MIMPID_VAL;
            CSR_MHARTID:   old_val = HART_ID;
            CSR_MSTATUS:   old_val = mstatus;
            CSR_MISA:      old_val = MISA_VAL;
            CSR_MIE:       old_val = mie_q;
            CSR_MTVEC:     old_val = mtvec_q;
            CSR_MSCRATCH:  old_val = mscratch_q;
            CSR_MEPC:      old_val = mepc_q;
            CSR_MCAUSE:    old_val = mcause_q;
            CSR_MTVAL:     old_val = mtval_q;
            default: begin
                old_val = 32'd0;
                addr_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (cmd_q.op)
            OP_SET:   new_val = old_val | cmd_q.wdata;
            OP_CLEAR: new_val = old_val & ~cmd_q.wdata;
            default:  new_val = cmd_q.wdata;
        endcase
    end

    assign is_csr = (cmd_q.op == OP_WRITE) || (cmd_q.op == OP_SET) || (cmd_q.op == OP_CLEAR);

    // Bits 11:10 both set marks a read-only CSR
    assign csr_illegal = is_csr && (!addr_ok || (cmd_q.wr_en && (cmd_q.addr[11:10] == 2'b11))
                         || (priv == PRIV_U));
    assign illegal     = (cmd_q.op == OP_ILLEGAL) || csr_illegal;
    assign trap        = busy && (illegal || (cmd_q.op == OP_ECALL));
    assign mret        = busy && (cmd_q.op == OP_MRET);
    assign csr_write   = busy && is_csr && !csr_illegal && cmd_q.wr_en;

    always_comb begin
        if (illegal) begin
            cause = CAUSE_ILLEGAL;
        end else if (priv == PRIV_U) begin
            cause = CAUSE_ECALL_U;
        end else begin
            cause = CAUSE_ECALL_M;
        end
    end

    csr_mstatus_reg mstatus_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .trap_take (trap),
        .mret_take (mret),
        .wr_en     (csr_write && (cmd_q.addr == CSR_MSTATUS)),
        .wdata     (new_val),
        .mstatus   (mstatus),
        .priv      (priv)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mie_q      <= 32'd0;
            mtvec_q    <= MEPC_RESET;
            mscratch_q <= 32'd0;
            mepc_q     <= MEPC_RESET;
            mcause_q   <= 32'd0;
            mtval_q    <= 32'd0;
        end else if (trap) begin
            mepc_q   <= cmd_q.pc;
            mcause_q <= cause;
            mtval_q  <= illegal ? cmd_q.instr : 32'd0;
        end else if (csr_write) begin
            case (cmd_q.addr)
                CSR_MIE:      mie_q      <= new_val & MIE_MASK;
                CSR_MTVEC:    mtvec_q    <= new_val & MTVEC_MASK;
                CSR_MSCRATCH: mscratch_q <= new_val;
                CSR_MEPC:     mepc_q     <= new_val;
                CSR_MCAUSE:   mcause_q   <= new_val;
                CSR_MTVAL:    mtval_q    <= new_val;
                default:      ;
            endcase
        end
    end

    // Response carries the pre-update value
    always_ff @(posedge clk) begin
        if (busy) begin
            rsp.rdata    <= (trap || mret) ? 32'd0 : old_val;
            rsp.redirect <= trap || mret;
            if (trap) begin
                rsp.target <= mtvec_q;
            end else if (mret) begin
                rsp.target <= mepc_q;
            end else begin
                rsp.target <= 32'd0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/csr_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top import csr_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 4,
    parameter logic [31:0] HART_ID    = 32'd0,
    parameter logic [31:0] MEPC_RESET = 32'h0001_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] pc,
    output logic        rsp_valid,
    output csr_rsp_t    rsp,
    output priv_e       priv,
    output logic        overflow
);

    logic     cmd_valid;
    csr_cmd_t cmd;
    csr_cmd_t head;
    logic     not_empty;
    logic     pop;

    csr_cmd_decoder decoder_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .pc          (pc),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd)
    );

    csr_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (cmd_valid),
        .push_cmd  (cmd),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .overflow  (overflow)
    );

    csr_file #(
        .HART_ID    (HART_ID),
        .MEPC_RESET (MEPC_RESET)
    ) csr_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (head),
        .not_empty (not_empty),
        .pop       (pop),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .priv      (priv)
    );

endmodule

`default_nettype wire

// ==== bench/csr_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb import csr_pkg::*; ();

    localparam logic [31:0] HART_ID    = 32'd0;
    localparam logic [31:0] MEPC_RESET = 32'h0001_0000;
    localparam int          FIFO_DEPTH = 4;
    localparam int          BURST_LEN  = FIFO_DEPTH + 1 + 12;
    localparam int          RSP_WAIT   = 16;
    localparam logic [31:0] ECALL_WORD = 32'h0000_0073;
    localparam logic [31:0] MRET_WORD  = 32'h3020_0073;
    localparam logic [31:0] BURST_BASE = 32'h2000_0000;

    // funct3 of the CSR forms
    localparam logic [2:0] F3_RW  = 3'd1;
    localparam logic [2:0] F3_RS  = 3'd2;
    localparam logic [2:0] F3_RC  = 3'd3;
    localparam logic [2:0] F3_RWI = 3'd5;
    localparam logic [2:0] F3_RSI = 3'd6;
    localparam logic [2:0] F3_RCI = 3'd7;

    typedef struct packed {
        logic [31:0] word;
        logic [31:0] rs1_val;
        logic [31:0] pc;
        csr_rsp_t    exp;
        priv_e       exp_priv;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs1_data;
    logic [31:0] pc;
    logic        rsp_valid;
    csr_rsp_t    rsp;
    priv_e       priv;
    logic        overflow;

    entry_t      table_q [$];
    csr_rsp_t    rsp_log [$];
    logic [31:0] next_pc;
    int          n_errors;
    int          n_checks;
    int          cycle_cnt;
    int          timeout_limit;

    // Reference model state
    logic [31:0] ref_mie;
    logic [31:0] ref_mtvec;
    logic [31:0] ref_mscratch;
    logic [31:0] ref_mepc;
    logic [31:0] ref_mcause;
    logic [31:0] ref_mtval;
    logic [31:0] ref_mstatus;
    priv_e       ref_priv;

    csr_unit_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .pc          (pc),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .priv        (priv),
        .overflow    (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Responses are logged mid-cycle
    always @(negedge clk) begin
        if (rst_n && rsp_valid) begin
            rsp_log.push_back(rsp);
        end
    end

    initial begin
        cycle_cnt = 0;
        wait (timeout_limit != 0);
        while (cycle_cnt < timeout_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] encode_csr(input logic [2:0] f3, input logic [11:0] addr,
                                               input logic [4:0] src);
        return {addr, src, f3, 5'd1, 7'b1110011};
    endfunction

    function automatic logic [31:0] read_word(input logic [11:0] addr);
        return encode_csr(F3_RS, addr, 5'd0);
    endfunction

    function automatic bit is_burst_value(input logic [31:0] v);
        return (v - BURST_BASE) < 32'd12;
    endfunction

    task automatic reset_model();
        ref_mie      = 32'd0;
        ref_mtvec    = MEPC_RESET;
        ref_mscratch = 32'd0;
        ref_mepc     = MEPC_RESET;
        ref_mcause   = 32'd0;
        ref_mtval    = 32'd0;
        ref_mstatus  = 32'd0;
        ref_priv     = PRIV_M;
    endtask

    task automatic lookup_csr(input logic [11:0] addr, output logic [31:0] val,
                              output logic known);
        known = 1'b1;
        case (addr)
            CSR_MVENDORID: val = 32'd0;
            CSR_MARCHID:   val = 32'd0;
            CSR_MIMPID:    val = 32'd1;
            CSR_MHARTID:   val = HART_ID;
            CSR_MISA:      val = 32'h4000_0100;
            CSR_MSTATUS:   val = ref_mstatus;
            CSR_MIE:       val = ref_mie;
            CSR_MTVEC:     val = ref_mtvec;
            CSR_MSCRATCH:  val = ref_mscratch;
            CSR_MEPC:      val = ref_mepc;
            CSR_MCAUSE:    val = ref_mcause;
            CSR_MTVAL:     val = ref_mtval;
            default: begin
                val   = 32'd0;
                known = 1'b0;
            end
        endcase
    endtask

    task automatic store_csr(input logic [11:0] addr, input logic [31:0] val);
        case (addr)
            CSR_MSTATUS: begin
                ref_mstatus[3] = val[3];
                ref_mstatus[7] = val[7];
                // MPP keeps only U and M
                if (val[12:11] == 2'b00 || val[12:11] == 2'b11) begin
                    ref_mstatus[12:11] = val[12:11];
                end
            end
            CSR_MIE:      ref_mie      = val & 32'h0000_0888;
            CSR_MTVEC:    ref_mtvec    = {val[31:2], 2'b00};
            CSR_MSCRATCH: ref_mscratch = val;
            CSR_MEPC:     ref_mepc     = val;
            CSR_MCAUSE:   ref_mcause   = val;
            CSR_MTVAL:    ref_mtval    = val;
            default:      ;
        endcase
    endtask

    task automatic enter_trap(input logic [31:0] cause, input logic [31:0] at_pc,
                              input logic [31:0] tval);
        ref_mepc           = at_pc;
        ref_mcause         = cause;
        ref_mtval          = tval;
        ref_mstatus[7]     = ref_mstatus[3];
        ref_mstatus[3]     = 1'b0;
        ref_mstatus[12:11] = ref_priv;
        ref_priv           = PRIV_M;
    endtask

    task automatic predict_rsp(input logic [31:0] word, input logic [31:0] rs1_val,
                               input logic [31:0] at_pc, output csr_rsp_t exp);
        logic [11:0] addr;
        logic [2:0]  f3;
        logic [4:0]  src_idx;
        logic [31:0] old;
        logic [31:0] src;
        logic [31:0] upd;
        logic        known;
        logic        wr;
        logic        bad;
        addr    = word[31:20];
        f3      = word[14:12];
        src_idx = word[19:15];
        exp     = '0;
        bad     = (word[6:0] != 7'b1110011) || (f3 == 3'd4);
        if (!bad && f3 == 3'd0 && addr == 12'h000) begin
            exp.redirect = 1'b1;
            exp.target   = ref_mtvec;
            enter_trap((ref_priv == PRIV_U) ? 32'd8 : 32'd11, at_pc, 32'd0);
        end else if (!bad && f3 == 3'd0 && addr == 12'h302) begin
            exp.redirect       = 1'b1;
            exp.target         = ref_mepc;
            ref_priv           = priv_e'(ref_mstatus[12:11]);
            ref_mstatus[3]     = ref_mstatus[7];
            ref_mstatus[7]     = 1'b1;
            ref_mstatus[12:11] = 2'b00;
        end else begin
            src = f3[2] ? {27'd0, src_idx} : rs1_val;
            wr  = (f3[1:0] == 2'd1) || (src_idx != 5'd0);
            lookup_csr(addr, old, known);
            bad = bad || (f3 == 3'd0) || !known || (wr && addr[11:10] == 2'b11)
                  || (ref_priv == PRIV_U);
            if (bad) begin
                exp.redirect = 1'b1;
                exp.target   = ref_mtvec;
                enter_trap(32'd2, at_pc, word);
            end else begin
                exp.rdata = old;
                case (f3[1:0])
                    2'd2:    upd = old | src;
                    2'd3:    upd = old & ~src;
                    default: upd = src;
                endcase
                if (wr) begin
                    store_csr(addr, upd);
                end
            end
        end
    endtask

    task automatic add_entry(input logic [31:0] word, input logic [31:0] rs1_val);
        entry_t e;
        e.word    = word;
        e.rs1_val = rs1_val;
        e.pc      = next_pc;
        predict_rsp(word, rs1_val, next_pc, e.exp);
        e.exp_priv = ref_priv;
        table_q.push_back(e);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic add_trap_reads();
        add_entry(read_word(CSR_MCAUSE), 32'd0);
        add_entry(read_word(CSR_MEPC), 32'd0);
        add_entry(read_word(CSR_MTVAL), 32'd0);
        add_entry(read_word(CSR_MSTATUS), 32'd0);
    endtask

    task automatic build_table();
        logic [11:0] id_addrs [8];
        id_addrs = '{CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID,
                     CSR_MISA, CSR_MEPC, CSR_MTVEC, CSR_MSTATUS};
        foreach (id_addrs[i]) begin
            add_entry(read_word(id_addrs[i]), 32'd0);
        end
        // Read-modify-write in register and immediate forms
        add_entry(encode_csr(F3_RW, CSR_MSCRATCH, 5'd5), 32'hdead_beef);
        add_entry(encode_csr(F3_RS, CSR_MSCRATCH, 5'd6), 32'h0000_00f0);
        add_entry(encode_csr(F3_RC, CSR_MSCRATCH, 5'd7), 32'hff00_0000);
        add_entry(encode_csr(F3_RS, CSR_MSCRATCH, 5'd0), 32'hffff_ffff);
        add_entry(encode_csr(F3_RC, CSR_MSCRATCH, 5'd0), 32'hffff_ffff);
        add_entry(encode_csr(F3_RWI, CSR_MIE, 5'h1f), 32'hffff_ffff);
        add_entry(encode_csr(F3_RS, CSR_MIE, 5'd5), 32'hffff_ffff);
        add_entry(encode_csr(F3_RCI, CSR_MIE, 5'd8), 32'd0);
        add_entry(encode_csr(F3_RSI, CSR_MIE, 5'd0), 32'd0);
        add_entry(encode_csr(F3_RW, CSR_MTVEC, 5'd5), 32'h0002_0103);
        add_entry(encode_csr(F3_RSI, CSR_MTVEC, 5'd3), 32'd0);
        add_entry(encode_csr(F3_RC, CSR_MTVEC, 5'd5), 32'h0000_0100);
        add_entry(encode_csr(F3_RCI, CSR_MTVEC, 5'd0), 32'd0);
        add_entry(read_word(CSR_MSCRATCH), 32'd0);
        add_entry(read_word(CSR_MIE), 32'd0);
        add_entry(read_word(CSR_MTVEC), 32'd0);
        // Illegal traps
        add_entry(32'h0000_0013, 32'd0);
        add_trap_reads();
        add_entry(read_word(12'h7c0), 32'd0);
        add_trap_reads();
        add_entry(encode_csr(F3_RW, CSR_MHARTID, 5'd5), 32'h0000_1234);
        add_trap_reads();
        // Privilege round trip
        // MPP=01 is ignored on the first write
        add_entry(encode_csr(F3_RW, CSR_MSTATUS, 5'd5), 32'h0000_0808);
        add_entry(encode_csr(F3_RC, CSR_MSTATUS, 5'd5), 32'h0000_1800);
        add_entry(encode_csr(F3_RS, CSR_MSTATUS, 5'd5), 32'h0000_0080);
        add_entry(encode_csr(F3_RW, CSR_MEPC, 5'd5), 32'h0004_0000);
        add_entry(MRET_WORD, 32'd0);
        add_entry(read_word(CSR_MSCRATCH), 32'd0);
        add_trap_reads();
        add_entry(MRET_WORD, 32'd0);
        add_entry(ECALL_WORD, 32'd0);
        add_trap_reads();
        add_entry(ECALL_WORD, 32'd0);
        add_trap_reads();
    endtask

    task automatic send_instr(input logic [31:0] word, input logic [31:0] rs1_val,
                              input logic [31:0] at_pc);
        instr_valid <= 1'b1;
        instr       <= word;
        rs1_data    <= rs1_val;
        pc          <= at_pc;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic drive_burst(input logic [31:0] base, input int n);
        for (int i = 0; i < n; i++) begin
            instr_valid <= 1'b1;
            instr       <= encode_csr(F3_RW, CSR_MSCRATCH, 5'd5);
            rs1_data    <= base + 32'(i);
            pc          <= next_pc;
            @(posedge clk);
        end
        instr_valid <= 1'b0;
    endtask

    task automatic wait_rsp(output csr_rsp_t got, output bit ok, output int waited);
        waited = 0;
        while (rsp_log.size() == 0 && waited < RSP_WAIT) begin
            @(posedge clk);
            waited++;
        end
        ok  = (rsp_log.size() != 0);
        got = ok ? rsp_log.pop_front() : '0;
    endtask

    task automatic check_rsp(input string what, input csr_rsp_t got, input csr_rsp_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] rsp (%s): got rdata=%h redirect=%h target=%h",
                     what, got.rdata, got.redirect, got.target);
            $display("       expected rdata=%h redirect=%h target=%h",
                     exp.rdata, exp.redirect, exp.target);
        end
    endtask

    task automatic check_priv(input priv_e got, input priv_e exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] priv: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
        end
    endtask

    initial begin
        csr_rsp_t    got;
        csr_rsp_t    exp;
        csr_rsp_t    burst_exp [$];
        bit          ok;
        bit          good;
        int          waited;
        int          n_rsp;
        logic [31:0] prev;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rs1_data    = '0;
        pc          = '0;
        next_pc     = 32'h0000_1000;
        reset_model();
        build_table();
        timeout_limit = table_q.size() * 8 + BURST_LEN * 8 + 50;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        foreach (table_q[i]) begin
            send_instr(table_q[i].word, table_q[i].rs1_val, table_q[i].pc);
            wait_rsp(got, ok, waited);
            if (!ok) begin
                n_errors++;
                $display("Entry %0d: no response from the DUT", i);
            end else begin
                if (waited != 4) begin
                    n_errors++;
                    $display("Entry %0d: response came %0d cycles after the strobe, not 4",
                             i, waited);
                end
                check_rsp($sformatf("entry %0d", i), got, table_q[i].exp);
                check_priv(priv, table_q[i].exp_priv);
            end
        end

        // Burst that fits in the FIFO returns each previous value in order
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            predict_rsp(encode_csr(F3_RW, CSR_MSCRATCH, 5'd5), 32'h1000_0000 + 32'(i),
                        next_pc, exp);
            burst_exp.push_back(exp);
        end
        drive_burst(32'h1000_0000, FIFO_DEPTH + 1);
        foreach (burst_exp[i]) begin
            wait_rsp(got, ok, waited);
            if (!ok) begin
                n_errors++;
                $display("Burst entry %0d: no response from the DUT", i);
            end else begin
                check_rsp($sformatf("burst %0d", i), got, burst_exp[i]);
            end
        end
        check_flag("overflow", overflow, 1'b0);

        // Surviving commands of an overflowing burst still come back in order
        drive_burst(BURST_BASE, 12);
        n_rsp = 0;
        prev  = 32'h1000_0000 + 32'(FIFO_DEPTH);
        wait_rsp(got, ok, waited);
        while (ok) begin
            n_rsp++;
            n_checks++;
            if (n_rsp == 1) begin
                good = (got.rdata == prev);
            end else begin
                good = is_burst_value(got.rdata) && (got.rdata > prev);
            end
            if (got.redirect || !good) begin
                n_errors++;
                $display("[FAIL] rsp.rdata: got %h, not in order after %h", got.rdata, prev);
            end
            prev = got.rdata;
            wait_rsp(got, ok, waited);
        end
        if (n_rsp == 0 || n_rsp >= 12) begin
            n_errors++;
            $display("Overflow burst gave %0d responses, expected some commands dropped", n_rsp);
        end
        check_flag("overflow", overflow, 1'b1);
        send_instr(read_word(CSR_MSCRATCH), 32'd0, next_pc);
        wait_rsp(got, ok, waited);
        n_checks++;
        if (!ok) begin
            n_errors++;
            $display("Final mscratch read: no response from the DUT");
        end else if (got.redirect || !is_burst_value(got.rdata)) begin
            n_errors++;
            $display("[FAIL] mscratch: got %h, not one of the burst values", got.rdata);
        end

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/csr_pkg.sv
hw/csr_cmd_decoder.sv
hw/csr_cmd_fifo.sv
hw/csr_mstatus_reg.sv
hw/csr_file.sv
hw/csr_unit_top.sv
bench/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - files:
      - hw/csr_pkg.sv
      - hw/csr_cmd_decoder.sv
      - hw/csr_cmd_fifo.sv
      - hw/csr_mstatus_reg.sv
      - hw/csr_file.sv
      - hw/csr_unit_top.sv
  - target: test
    files:
      - bench/csr_unit_tb.sv
